// ==== hw/tracker_pkg.sv ====
`default_nettype none

package tracker_pkg;

  // video timing widths
  localparam int HCOUNT_W = 11;
  localparam int VCOUNT_W = 10;

  // accumulator and masked-pixel counter widths
  localparam int SUM_W   = 32;
  localparam int COUNT_W = 21;

  // inclusive chroma bounds
  localparam logic [7:0] CR_LOWER_DEFAULT = 8'd160;
  localparam logic [7:0] CR_UPPER_DEFAULT = 8'd240;

  // expansion reg plus three conversion stages
  localparam int SEG_LATENCY = 4;

  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } pixel565_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb888_t;

  typedef struct packed {
    logic [HCOUNT_W-1:0] x;
    logic [VCOUNT_W-1:0] y;
  } coord_t;

  // one pixel from the frame buffer read port
  typedef struct packed {
    pixel565_t pixel;
    coord_t    coord;
    logic      active;
    logic      frame_start;
  } video_in_t;

  // threshold result, aligned with its pixel
  typedef struct packed {
    coord_t coord;
    logic   active;
    logic   frame_start;
    logic   cr_hit;
    logic   cb_hit;
  } mask_t;

  typedef struct packed {
    rgb888_t pixel;
    coord_t  coord;
    logic    active;
  } video_out_t;

  // 565 to 888 by zero fill of the low bits
  function automatic rgb888_t expand_565(input pixel565_t p);
    expand_565 = '{red: {p.red, 3'b000}, green: {p.green, 2'b00}, blue: {p.blue, 3'b000}};
  endfunction

endpackage

`default_nettype wire

// ==== hw/rgb_to_ycrcb.sv ====
`default_nettype none

module rgb_to_ycrcb (
  input  wire                  clk_camera,
  input  wire                  sys_rst_pixel,
  input  tracker_pkg::rgb888_t rgb_i,
  output logic [7:0]           cr_o,
  output logic [7:0]           cb_o,
  output logic [7:0]           y_o
);

  // channels as non-negative signed operands
  logic signed [8:0] r_s;
  logic signed [8:0] g_s;
  logic signed [8:0] b_s;

  // stage 1 products, all weights kept positive
  logic signed [17:0] cr_r, cr_g, cr_b;
  logic signed [17:0] cb_r, cb_g, cb_b;
  logic signed [17:0] y_r, y_g, y_b;

  // stage 2 signed sums with rounding
  logic signed [17:0] cr_sum, cb_sum, y_sum;

  // stage 3 inputs after shift and offset
  logic signed [17:0] cr_val, cb_val, y_val;

  // clamp to 0..255
  function automatic logic [7:0] sat8(input logic signed [17:0] v);
    if (v < 0)
      sat8 = 8'd0;
    else if (v > 18'sd255)
      sat8 = 8'd255;
    else
      sat8 = v[7:0];
  endfunction

  assign r_s = $signed({1'b0, rgb_i.red});
  assign g_s = $signed({1'b0, rgb_i.green});
  assign b_s = $signed({1'b0, rgb_i.blue});

  always_ff @(posedge clk_camera)
  begin
    // BT.601 weights
    cr_r <= 18'sd112 * r_s;
    cr_g <= 18'sd94 * g_s;
    cr_b <= 18'sd18 * b_s;
    cb_r <= 18'sd38 * r_s;
    cb_g <= 18'sd74 * g_s;
    cb_b <= 18'sd112 * b_s;
    y_r  <= 18'sd66 * r_s;
    y_g  <= 18'sd129 * g_s;
    y_b  <= 18'sd25 * b_s;
    // signs applied here, +128 rounds the later shift
    cr_sum <= cr_r - cr_g - cr_b + 18'sd128;
    cb_sum <= cb_b - cb_r - cb_g + 18'sd128;
    y_sum  <= y_r + y_g + y_b + 18'sd128;
  end

  // arithmetic shift keeps negative chroma floored
  assign cr_val = (cr_sum >>> 8) + 18'sd128;
  assign cb_val = (cb_sum >>> 8) + 18'sd128;
  assign y_val  = (y_sum >>> 8) + 18'sd16;

  always_ff @(posedge clk_camera)
  begin
    if (sys_rst_pixel)
    begin
      cr_o <= 8'd0;
      cb_o <= 8'd0;
      y_o  <= 8'd0;
    end
    else
    begin
      cr_o <= sat8(cr_val);
      cb_o <= sat8(cb_val);
      y_o  <= sat8(y_val);
    end
  end

endmodule

`default_nettype wire

// ==== hw/chroma_segmenter.sv ====
`default_nettype none

module chroma_segmenter #(
  parameter logic [7:0] CR_LOWER = tracker_pkg::CR_LOWER_DEFAULT,
  parameter logic [7:0] CR_UPPER = tracker_pkg::CR_UPPER_DEFAULT,
  parameter logic [7:0] CB_LOWER = tracker_pkg::CR_LOWER_DEFAULT,
  parameter logic [7:0] CB_UPPER = tracker_pkg::CR_UPPER_DEFAULT
) (
  input  wire                    clk_camera,
  input  wire                    sys_rst_pixel,
  input  tracker_pkg::video_in_t video_i,
  output tracker_pkg::mask_t     mask_o
);

  localparam int DEPTH = tracker_pkg::SEG_LATENCY;

  // expanded pixel, first pipeline stage
  tracker_pkg::rgb888_t rgb_q;
  logic [7:0] cr;
  logic [7:0] cb;

  // coordinates and flags ride alongside the conversion
  tracker_pkg::coord_t crd_d [DEPTH];
  logic [DEPTH-1:0] act_d;
  logic [DEPTH-1:0] fs_d;

  always_ff @(posedge clk_camera)
  begin
    rgb_q <= tracker_pkg::expand_565(video_i.pixel);
    crd_d[0] <= video_i.coord;
    for (int i = 1; i < DEPTH; i++)
      crd_d[i] <= crd_d[i-1];
  end

  always_ff @(posedge clk_camera)
  begin
    if (sys_rst_pixel)
    begin
      act_d <= '0;
      fs_d  <= '0;
    end
    else
    begin
      act_d <= {act_d[DEPTH-2:0], video_i.active};
      fs_d  <= {fs_d[DEPTH-2:0], video_i.frame_start};
    end
  end

  // three cycles, so cr/cb line up with the last delay tap
  rgb_to_ycrcb u_ycrcb (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .rgb_i         (rgb_q),
    .cr_o          (cr),
    .cb_o          (cb),
    // luma not needed for tracking
    .y_o           ()
  );

  // bounds inclusive; blanking never hits
  always_comb
  begin
    mask_o.coord       = crd_d[DEPTH-1];
    mask_o.active      = act_d[DEPTH-1];
    mask_o.frame_start = fs_d[DEPTH-1];
    mask_o.cr_hit      = act_d[DEPTH-1] && (cr >= CR_LOWER) && (cr <= CR_UPPER);
    mask_o.cb_hit      = act_d[DEPTH-1] && (cb >= CB_LOWER) && (cb <= CB_UPPER);
  end

endmodule

`default_nettype wire

// ==== hw/centroid_divider.sv ====
`default_nettype none

module centroid_divider (
  input  wire                                clk_camera,
  input  wire                                sys_rst_pixel,
  input  wire                                start_i,
  input  wire [tracker_pkg::SUM_W-1:0]       sum_x_i,
  input  wire [tracker_pkg::SUM_W-1:0]       sum_y_i,
  input  wire [tracker_pkg::COUNT_W-1:0]     count_i,
  output logic                               busy_o,
  output logic                               done_o,
  output tracker_pkg::coord_t                quotient_o
);

  localparam int SUM_W   = tracker_pkg::SUM_W;
  localparam int COUNT_W = tracker_pkg::COUNT_W;
  localparam int STEP_W  = $clog2(SUM_W + 1);

  // numerators shift out at the top, quotient bits shift in at the bottom
  logic [SUM_W-1:0]   num_x, num_y;
  logic [COUNT_W-1:0] rem_x, rem_y;
  logic [COUNT_W-1:0] den;
  logic [STEP_W-1:0]  steps;
  logic [COUNT_W:0]   step_x, step_y;

  // one restoring step, returns {remainder, quotient bit}
  function automatic logic [COUNT_W:0] div_step(
    input logic [COUNT_W-1:0] rem,
    input logic               msb,
    input logic [COUNT_W-1:0] den_v
  );
    logic [COUNT_W:0] trial;
    logic [COUNT_W:0] diff;
    trial = {rem, msb};
    diff  = trial - {1'b0, den_v};
    if (trial >= {1'b0, den_v})
      div_step = {diff[COUNT_W-1:0], 1'b1};
    else
      div_step = {trial[COUNT_W-1:0], 1'b0};
  endfunction

  // both means share the same divisor
  assign step_x = div_step(rem_x, num_x[SUM_W-1], den);
  assign step_y = div_step(rem_y, num_y[SUM_W-1], den);

  always_ff @(posedge clk_camera)
  begin
    if (start_i && !busy_o)
    begin
      num_x <= sum_x_i;
      num_y <= sum_y_i;
      den   <= count_i;
      rem_x <= '0;
      rem_y <= '0;
    end
    else if (busy_o)
    begin
      rem_x <= step_x[COUNT_W:1];
      rem_y <= step_y[COUNT_W:1];
      num_x <= {num_x[SUM_W-2:0], step_x[0]};
      num_y <= {num_y[SUM_W-2:0], step_y[0]};
    end
  end

  // done rises with the last step, SUM_W+1 cycles after start
  always_ff @(posedge clk_camera)
  begin
    if (sys_rst_pixel)
    begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
      steps  <= '0;
    end
    else
    begin
      done_o <= 1'b0;
      if (start_i && !busy_o)
      begin
        busy_o <= 1'b1;
        steps  <= STEP_W'(SUM_W);
      end
      else if (busy_o)
      begin
        steps <= steps - 1'b1;
        if (steps == STEP_W'(1))
        begin
          busy_o <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  // means of on-screen coordinates fit the coordinate widths
  assign quotient_o.x = num_x[tracker_pkg::HCOUNT_W-1:0];
  assign quotient_o.y = num_y[tracker_pkg::VCOUNT_W-1:0];

endmodule

`default_nettype wire

// ==== hw/centroid_accumulator.sv ====
`default_nettype none

module centroid_accumulator #(
  parameter bit USE_CB = 1'b0
) (
  input  wire                 clk_camera,
  input  wire                 sys_rst_pixel,
  input  tracker_pkg::mask_t  mask_i,
  output tracker_pkg::coord_t centroid_o,
  output logic                centroid_update_o
);

  localparam int SUM_W    = tracker_pkg::SUM_W;
  localparam int COUNT_W  = tracker_pkg::COUNT_W;
  localparam int HCOUNT_W = tracker_pkg::HCOUNT_W;
  localparam int VCOUNT_W = tracker_pkg::VCOUNT_W;

  logic                hit;
  logic [SUM_W-1:0]    x_ext, y_ext;
  logic [SUM_W-1:0]    sum_x, sum_y;
  logic [COUNT_W-1:0]  count;
  logic                div_start;
  logic                div_busy;
  logic                div_done;
  tracker_pkg::coord_t quotient;

  // channel chosen per instance
  assign hit = USE_CB ? mask_i.cb_hit : mask_i.cr_hit;

  assign x_ext = {{(SUM_W-HCOUNT_W){1'b0}}, mask_i.coord.x};
  assign y_ext = {{(SUM_W-VCOUNT_W){1'b0}}, mask_i.coord.y};

  // empty frames and busy divider skip the division
  assign div_start = mask_i.frame_start && (count != '0) && !div_busy;

  always_ff @(posedge clk_camera)
  begin
    if (sys_rst_pixel)
    begin
      sum_x <= '0;
      sum_y <= '0;
      count <= '0;
    end
    else if (mask_i.frame_start)
    begin
      // frame_start pixel opens the new frame
      sum_x <= hit ? x_ext : '0;
      sum_y <= hit ? y_ext : '0;
      count <= hit ? COUNT_W'(1) : '0;
    end
    else if (hit)
    begin
      sum_x <= sum_x + x_ext;
      sum_y <= sum_y + y_ext;
      count <= count + 1'b1;
    end
  end

  // divider latches the sums before they clear
  centroid_divider u_div (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .start_i       (div_start),
    .sum_x_i       (sum_x),
    .sum_y_i       (sum_y),
    .count_i       (count),
    .busy_o        (div_busy),
    .done_o        (div_done),
    .quotient_o    (quotient)
  );

  // update pulse coincides with the new held value
  always_ff @(posedge clk_camera)
  begin
    if (sys_rst_pixel)
    begin
      centroid_o        <= '0;
      centroid_update_o <= 1'b0;
    end
    else
    begin
      centroid_update_o <= div_done;
      if (div_done)
        centroid_o <= quotient;
    end
  end

endmodule

`default_nettype wire

// ==== hw/crosshair_overlay.sv ====
`default_nettype none

module crosshair_overlay (
  input  wire                     clk_camera,
  input  wire                     sys_rst_pixel,
  input  tracker_pkg::video_in_t  video_i,
  input  tracker_pkg::coord_t     centroid_a_i,
  input  tracker_pkg::coord_t     centroid_b_i,
  output tracker_pkg::video_out_t video_o
);

  localparam int DEPTH = tracker_pkg::SEG_LATENCY;

  // camera image delayed to match the segmenter
  tracker_pkg::pixel565_t pix_d [DEPTH];
  tracker_pkg::coord_t    crd_d [DEPTH];
  logic [DEPTH-1:0]       act_d;

  tracker_pkg::coord_t    crd_n;
  logic                   on_line;

  // output register
  tracker_pkg::rgb888_t   rgb_q;
  tracker_pkg::coord_t    crd_q;
  logic                   act_q;

  always_ff @(posedge clk_camera)
  begin
    pix_d[0] <= video_i.pixel;
    crd_d[0] <= video_i.coord;
    for (int i = 1; i < DEPTH; i++)
    begin
      pix_d[i] <= pix_d[i-1];
      crd_d[i] <= crd_d[i-1];
    end
  end

  assign crd_n = crd_d[DEPTH-1];

  // vertical line at either x, horizontal at either y
  assign on_line = (crd_n.x == centroid_a_i.x) || (crd_n.x == centroid_b_i.x) ||
                   (crd_n.y == centroid_a_i.y) || (crd_n.y == centroid_b_i.y);

  always_ff @(posedge clk_camera)
  begin
    crd_q <= crd_n;
    // blanking black, crosshair white, otherwise camera
    if (!act_d[DEPTH-1])
      rgb_q <= '0;
    else if (on_line)
      rgb_q <= '{red: 8'hFF, green: 8'hFF, blue: 8'hFF};
    else
      rgb_q <= tracker_pkg::expand_565(pix_d[DEPTH-1]);
  end

  always_ff @(posedge clk_camera)
  begin
    if (sys_rst_pixel)
    begin
      act_d <= '0;
      act_q <= 1'b0;
    end
    else
    begin
      act_d <= {act_d[DEPTH-2:0], video_i.active};
      act_q <= act_d[DEPTH-1];
    end
  end

  assign video_o = '{pixel: rgb_q, coord: crd_q, active: act_q};

endmodule

`default_nettype wire

// ==== hw/color_tracker_top.sv ====
`default_nettype none

module color_tracker_top #(
  parameter logic [7:0] CR_LOWER = tracker_pkg::CR_LOWER_DEFAULT,
  parameter logic [7:0] CR_UPPER = tracker_pkg::CR_UPPER_DEFAULT,
  parameter logic [7:0] CB_LOWER = tracker_pkg::CR_LOWER_DEFAULT,
  parameter logic [7:0] CB_UPPER = tracker_pkg::CR_UPPER_DEFAULT
) (
  input  wire                     clk_camera,
  input  wire                     sys_rst_pixel,
  input  tracker_pkg::video_in_t  video_i,
  output tracker_pkg::video_out_t video_o,
  output tracker_pkg::coord_t     cr_centroid_o,
  output tracker_pkg::coord_t     cb_centroid_o,
  output logic                    cr_update_o,
  output logic                    cb_update_o
);

  // thresholded stream, SEG_LATENCY behind video_i
  tracker_pkg::mask_t seg_mask;

  chroma_segmenter #(
    .CR_LOWER (CR_LOWER),
    .CR_UPPER (CR_UPPER),
    .CB_LOWER (CB_LOWER),
    .CB_UPPER (CB_UPPER)
  ) u_seg (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .video_i       (video_i),
    .mask_o        (seg_mask)
  );

  // red target tracks Cr
  centroid_accumulator #(
    .USE_CB (1'b0)
  ) u_cr_acc (
    .clk_camera        (clk_camera),
    .sys_rst_pixel     (sys_rst_pixel),
    .mask_i            (seg_mask),
    .centroid_o        (cr_centroid_o),
    .centroid_update_o (cr_update_o)
  );

  // blue target tracks Cb
  centroid_accumulator #(
    .USE_CB (1'b1)
  ) u_cb_acc (
    .clk_camera        (clk_camera),
    .sys_rst_pixel     (sys_rst_pixel),
    .mask_i            (seg_mask),
    .centroid_o        (cb_centroid_o),
    .centroid_update_o (cb_update_o)
  );

  // output image five cycles behind input
  crosshair_overlay u_overlay (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .video_i       (video_i),
    .centroid_a_i  (cr_centroid_o),
    .centroid_b_i  (cb_centroid_o),
    .video_o       (video_o)
  );

endmodule

`default_nettype wire

// ==== tests/color_tracker_assertions.sv ====
`default_nettype none

module color_tracker_assertions (
  input wire                     clk_camera,
  input wire                     sys_rst_pixel,
  input tracker_pkg::video_in_t  video_in_i,
  input tracker_pkg::video_out_t video_out_i,
  input wire                     cr_update_i,
  input wire                     cb_update_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // centroid updates are single-cycle strobes
  cr_pulse_width: assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
    cr_update_i |=> !cr_update_i)
    else $error("cr_update_o stayed high for more than one cycle");

  cb_pulse_width: assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
    cb_update_i |=> !cb_update_i)
    else $error("cb_update_o stayed high for more than one cycle");

  // overlay output trails the input by five cycles
  active_latency: assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
    video_out_i.active == $past(video_in_i.active, 5))
    else $error("video_o.active does not match video_i.active five cycles earlier");

  // reset keeps both strobes quiet
  quiet_in_reset: assert property (@(posedge clk_camera)
    sys_rst_pixel |=> !cr_update_i && !cb_update_i)
    else $error("centroid update strobe high during reset");

endmodule

bind color_tracker_top color_tracker_assertions u_assertions (
  .clk_camera    (clk_camera),
  .sys_rst_pixel (sys_rst_pixel),
  .video_in_i    (video_i),
  .video_out_i   (video_o),
  .cr_update_i   (cr_update_o),
  .cb_update_i   (cb_update_o)
);

`default_nettype wire

// ==== tests/color_tracker_tb.sv ====
`default_nettype none

module color_tracker_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // frame geometry, active area plus blanking
  localparam int H_ACTIVE     = 64;
  localparam int V_ACTIVE     = 32;
  localparam int H_TOTAL      = 80;
  localparam int V_TOTAL      = 34;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_FRAMES   = 6;

  // every frame plus the flush frame, each with room for two divisions
  localparam int TIMEOUT_CYCLES =
    (NUM_FRAMES + 1) * (FRAME_CYCLES + 2 * (tracker_pkg::SUM_W + 1)) + RESET_CYCLES + 200;

  typedef struct packed {
    logic                red_on;
    tracker_pkg::coord_t red_lo;
    tracker_pkg::coord_t red_hi;
    logic                blue_on;
    tracker_pkg::coord_t blue_lo;
    tracker_pkg::coord_t blue_hi;
    tracker_pkg::coord_t cr_exp;
    tracker_pkg::coord_t cb_exp;
  } frame_case_t;

  // rectangles are inclusive, expected centroid is floor((lo + hi) / 2) per axis
  localparam frame_case_t FRAMES [NUM_FRAMES] = '{
    // red only
    '{1'b1, '{11'd10, 10'd4}, '{11'd19, 10'd11}, 1'b0, '0, '0, '{11'd14, 10'd7}, '0},
    // blue only
    '{1'b0, '0, '0, 1'b1, '{11'd40, 10'd20}, '{11'd51, 10'd27}, '0, '{11'd45, 10'd23}},
    // noise only, no pulse expected
    '{1'b0, '0, '0, 1'b0, '0, '0, '0, '0},
    // both targets
    '{1'b1, '{11'd30, 10'd0}, '{11'd33, 10'd3}, 1'b1, '{11'd50, 10'd25}, '{11'd63, 10'd31},
      '{11'd31, 10'd1}, '{11'd56, 10'd28}},
    // single red pixel at the last active position
    '{1'b1, '{11'd63, 10'd31}, '{11'd63, 10'd31}, 1'b0, '0, '0, '{11'd63, 10'd31}, '0},
    // red block covering the frame_start pixel
    '{1'b1, '{11'd0, 10'd0}, '{11'd5, 10'd2}, 1'b0, '0, '0, '{11'd2, 10'd1}, '0}
  };
  localparam frame_case_t FLUSH = '0;

  localparam tracker_pkg::pixel565_t RED_565  = '{red: 5'd31, green: 6'd0, blue: 5'd0};
  localparam tracker_pkg::pixel565_t BLUE_565 = '{red: 5'd0, green: 6'd0, blue: 5'd31};
  // brightest dim noise in the direction of each chroma axis
  localparam tracker_pkg::pixel565_t DIM_RED  = '{red: 5'd3, green: 6'd0, blue: 5'd0};
  localparam tracker_pkg::pixel565_t DIM_BLUE = '{red: 5'd0, green: 6'd0, blue: 5'd3};

  logic                    clk_camera;
  logic                    sys_rst_pixel;
  tracker_pkg::video_in_t  video_i;
  tracker_pkg::video_out_t video_o;
  tracker_pkg::coord_t     cr_centroid_o;
  tracker_pkg::coord_t     cb_centroid_o;
  logic                    cr_update_o;
  logic                    cb_update_o;

  // driven pixels waiting for their output, and pending frame results
  tracker_pkg::video_in_t history [$];
  tracker_pkg::coord_t    cr_expect [$];
  tracker_pkg::coord_t    cb_expect [$];
  tracker_pkg::coord_t    held_cr = '0;
  tracker_pkg::coord_t    held_cb = '0;

  int          pushed_total = 0;
  int          checks_done  = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  int          cycle_count  = 0;

  color_tracker_top dut0 (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .video_i       (video_i),
    .video_o       (video_o),
    .cr_centroid_o (cr_centroid_o),
    .cb_centroid_o (cb_centroid_o),
    .cr_update_o   (cr_update_o),
    .cb_update_o   (cb_update_o)
  );

  initial
  begin
    clk_camera = 1'b0;
    forever #4 clk_camera = ~clk_camera;
  end

  // BT.601 integer chroma, pixel expanded with zero low bits
  function automatic int chroma(input int kr, input int kg, input int kb,
                                input tracker_pkg::pixel565_t p);
    int r;
    int g;
    int b;
    int v;
    r = int'(p.red) * 8;
    g = int'(p.green) * 4;
    b = int'(p.blue) * 8;
    v = ((kr * r + kg * g + kb * b + 128) >>> 8) + 128;
    if (v < 0)
      v = 0;
    else if (v > 255)
      v = 255;
    return v;
  endfunction

  function automatic logic in_band(input int v);
    return (v >= int'(tracker_pkg::CR_LOWER_DEFAULT)) &&
           (v <= int'(tracker_pkg::CR_UPPER_DEFAULT));
  endfunction

  function automatic logic in_rect(input tracker_pkg::coord_t c,
                                   input tracker_pkg::coord_t lo,
                                   input tracker_pkg::coord_t hi);
    return (c.x >= lo.x) && (c.x <= hi.x) && (c.y >= lo.y) && (c.y <= hi.y);
  endfunction

  // white on either centroid line, camera pixel otherwise, black in blanking
  function automatic tracker_pkg::video_out_t expected_out(input tracker_pkg::video_in_t vin,
                                                           input tracker_pkg::coord_t a,
                                                           input tracker_pkg::coord_t b);
    tracker_pkg::video_out_t o;
    o.coord  = vin.coord;
    o.active = vin.active;
    if (!vin.active)
      o.pixel = '0;
    else if (vin.coord.x == a.x || vin.coord.x == b.x ||
             vin.coord.y == a.y || vin.coord.y == b.y)
      o.pixel = 24'hFF_FFFF;
    else
      o.pixel = {vin.pixel.red, 3'b000, vin.pixel.green, 2'b00, vin.pixel.blue, 3'b000};
    return o;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks_done++;
    assert (got === exp)
    else
    begin
      value_errors++;
      $display("[FAIL] t=%0t %s expected=%0h got=%0h", $time, name, exp, got);
    end
  endtask

  // stimulus colours must land where the frame table assumes
  task automatic check_hits(input string what, input tracker_pkg::pixel565_t p,
                            input logic cr_exp, input logic cb_exp);
    logic cr_in;
    logic cb_in;
    cr_in = in_band(chroma(112, -94, -18, p));
    cb_in = in_band(chroma(-38, -74, 112, p));
    assert (cr_in == cr_exp && cb_in == cb_exp)
    else
    begin
      other_errors++;
      $display("chroma rule gives unexpected hits for %s (cr=%0b cb=%0b)", what, cr_in, cb_in);
    end
  endtask

  task automatic send_pixel(input tracker_pkg::video_in_t vin);
    @(posedge clk_camera);
    video_i <= vin;
    history.push_back(vin);
    pushed_total++;
  endtask

  task automatic drive_frame(input frame_case_t fc);
    tracker_pkg::video_in_t vin;
    for (int v = 0; v < V_TOTAL; v++)
    begin
      for (int h = 0; h < H_TOTAL; h++)
      begin
        vin.coord.x     = tracker_pkg::HCOUNT_W'(h);
        vin.coord.y     = tracker_pkg::VCOUNT_W'(v);
        vin.active      = (h < H_ACTIVE) && (v < V_ACTIVE);
        vin.frame_start = (h == 0) && (v == 0);
        // dim background noise
        vin.pixel.red   = 5'($urandom() % 4);
        vin.pixel.green = 6'($urandom() % 8);
        vin.pixel.blue  = 5'($urandom() % 4);
        if (fc.red_on && in_rect(vin.coord, fc.red_lo, fc.red_hi))
          vin.pixel = RED_565;
        else if (fc.blue_on && in_rect(vin.coord, fc.blue_lo, fc.blue_hi))
          vin.pixel = BLUE_565;
        send_pixel(vin);
      end
    end
  endtask

  // results of a finished frame, due after the next frame start
  task automatic queue_results(input frame_case_t fc);
    if (fc.red_on)
      cr_expect.push_back(fc.cr_exp);
    if (fc.blue_on)
      cb_expect.push_back(fc.cb_exp);
  endtask

  task automatic print_counts();
    $display("checks=%0d value_errors=%0d other_errors=%0d",
             checks_done, value_errors, other_errors);
  endtask

  // outputs settle after the rising edge, sample on the falling one
  always @(negedge clk_camera)
  begin : check_outputs
    tracker_pkg::video_in_t  vin;
    tracker_pkg::video_out_t exp_out;
    if (history.size() > 5)
    begin
      vin     = history.pop_front();
      exp_out = expected_out(vin, held_cr, held_cb);
      check_value("video_o.active", 32'(video_o.active), 32'(exp_out.active));
      check_value("video_o.coord", 32'(video_o.coord), 32'(exp_out.coord));
      check_value("video_o.pixel", 32'(video_o.pixel), 32'(exp_out.pixel));
    end
    else if (pushed_total <= 5)
      check_value("video_o.active", 32'(video_o.active), 32'd0);
    // held value changes with the pulse
    if (cr_update_o)
    begin
      assert (cr_expect.size() != 0)
      else
      begin
        other_errors++;
        $display("cr_update_o pulsed at %0t with no Cr target in the finished frame", $time);
      end
      if (cr_expect.size() != 0)
        held_cr = cr_expect.pop_front();
    end
    if (cb_update_o)
    begin
      assert (cb_expect.size() != 0)
      else
      begin
        other_errors++;
        $display("cb_update_o pulsed at %0t with no Cb target in the finished frame", $time);
      end
      if (cb_expect.size() != 0)
        held_cb = cb_expect.pop_front();
    end
    check_value("cr_centroid_o", 32'(cr_centroid_o), 32'(held_cr));
    check_value("cb_centroid_o", 32'(cb_centroid_o), 32'(held_cb));
  end

  initial
  begin
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk_camera);
      cycle_count++;
    end
    $display("timeout after %0d cycles with centroid results still outstanding",
             TIMEOUT_CYCLES);
    print_counts();
    $display("sim failed");
    $finish;
  end

  initial
  begin : run_frames
    int tail;
    // fixed seed for the background noise
    void'($urandom(51));
    sys_rst_pixel = 1'b1;
    video_i       = '0;
    check_hits("red target", RED_565, 1'b1, 1'b0);
    check_hits("blue target", BLUE_565, 1'b0, 1'b1);
    check_hits("dim red noise", DIM_RED, 1'b0, 1'b0);
    check_hits("dim blue noise", DIM_BLUE, 1'b0, 1'b0);
    repeat (RESET_CYCLES) @(posedge clk_camera);
    sys_rst_pixel <= 1'b0;
    for (int f = 0; f < NUM_FRAMES; f++)
    begin
      drive_frame(FRAMES[f]);
      queue_results(FRAMES[f]);
    end
    // last frame start launches the final division
    drive_frame(FLUSH);
    // idle tail until both results are in and the pipeline has drained
    tail = 0;
    while (cr_expect.size() != 0 || cb_expect.size() != 0 || tail < 8)
    begin
      send_pixel('0);
      tail++;
    end
    @(posedge clk_camera);
    print_counts();
    if (value_errors == 0 && other_errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
hw/tracker_pkg.sv
hw/rgb_to_ycrcb.sv
hw/chroma_segmenter.sv
hw/centroid_divider.sv
hw/centroid_accumulator.sv
hw/crosshair_overlay.sv
hw/color_tracker_top.sv
tests/color_tracker_assertions.sv
tests/color_tracker_tb.sv

// ==== Makefile ====
TOP := color_tracker_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

# the log decides pass or fail, whatever the binary's exit status
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
